/* src/bf_cipher_pkg.sv */
// Blowfish key schedule constants
// P_INIT holds the eighteen pi-derived words plus two extra digits
// widths are fixed by the cipher and are not meant to be changed
`default_nettype none

package bf_cipher_pkg;

	// one cipher word
	typedef logic [31:0] word_t;

	// P-array and key sizes in words
	localparam int P_COUNT       = 20;
	localparam int KEY_WORDS_MAX = 14;

	typedef logic [4:0] p_idx_t;
	typedef logic [3:0] key_idx_t;
	typedef logic [3:0] key_len_t;

	// ----------------------------------------
	// initial digits, entry 0 first
	// ----------------------------------------
	localparam word_t P_INIT [P_COUNT] = '{
		32'h243F_6A88,
		32'h85A3_08D3,
		32'h1319_8A2E,
		32'h0370_7344,
		32'hA409_3822,
		32'h299F_31D0,
		32'h082E_FA98,
		32'hEC4E_6C89,
		32'h4528_21E6,
		32'h38D0_1377,
		32'hBE54_66CF,
		32'h34E9_0C6C,
		32'hC0AC_29B7,
		32'hC97C_50DD,
		32'h3F84_D5B5,
		32'hB547_0917,
		32'h9216_D5D9,
		32'h8979_FB1B,
		32'h578F_DFE3,
		32'h3AC3_72E6
	};

endpackage

`default_nettype wire

/* src/bf_regmap_pkg.sv */
// Wishbone word address map and mixer state encoding
// only full-word accesses, no byte selects
`default_nettype none

package bf_regmap_pkg;

	typedef logic [5:0] adr_t;

	// key words at 0x00..0x0D, subkeys at 0x20..0x33
	localparam adr_t ADR_KEY_BASE    = 6'h00;
	localparam adr_t ADR_CTRL        = 6'h10;
	localparam adr_t ADR_KEYLEN      = 6'h11;
	localparam adr_t ADR_STATUS      = 6'h12;
	localparam adr_t ADR_SUBKEY_BASE = 6'h20;

	// control and status bit positions
	localparam int CTRL_START   = 0;
	localparam int CTRL_DECRYPT = 1;
	localparam int STAT_READY   = 0;
	localparam int STAT_BUSY    = 1;
	localparam int STAT_LEN_ERR = 2;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MIX,
		ST_DONE
	} mix_state_t;

endpackage

`default_nettype wire

/* src/bf_key_if.sv */
// Link between the register block and the P-array mixer
// key_word and sub_word are combinational lookups of the requested index
`timescale 1ns/1ps
`default_nettype none

interface bf_key_if;
	import bf_cipher_pkg::*;

	logic     start;
	key_len_t key_len;
	key_idx_t key_idx;
	word_t    key_word;
	logic     busy;
	logic     ready;
	p_idx_t   sub_idx;
	word_t    sub_word;

	modport regs (
		output start, key_len, key_word, sub_idx,
		input  key_idx, busy, ready, sub_word
	);

	modport mixer (
		input  start, key_len, key_word, sub_idx,
		output key_idx, busy, ready, sub_word
	);

endinterface

`default_nettype wire

/* src/bf_wb_regs.sv */
// Wishbone classic slave, ack one cycle after cyc and stb, no wait states
// key length 0 or 15 is rejected and sets the length error
// key and length writes are dropped while the mixer is busy
`timescale 1ns/1ps
`default_nettype none

module bf_wb_regs (
	input  logic                 Clk,
	input  logic                 RstN,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  bf_regmap_pkg::adr_t  wb_adr,
	input  bf_cipher_pkg::word_t wb_dat_w,
	output bf_cipher_pkg::word_t wb_dat_r,
	output logic                 wb_ack,
	bf_key_if.regs               key
);
	import bf_cipher_pkg::*;
	import bf_regmap_pkg::*;

	word_t    key_mem [KEY_WORDS_MAX];
	key_len_t key_len_q;
	logic     decrypt_q;
	logic     len_err_q;
	logic     start_q;

	logic     access;
	logic     wr;
	adr_t     key_rel;
	adr_t     sub_rel;
	logic     key_sel;
	logic     sub_sel;
	key_idx_t key_off;
	p_idx_t   sub_off;
	logic     len_ok;
	word_t    rd_data;

	// ----------------------------------------
	// bus decode
	// ----------------------------------------
	// no new access in the ack cycle
	assign access = wb_cyc && wb_stb && !wb_ack;
	assign wr     = access && wb_we;

	assign key_rel = wb_adr - ADR_KEY_BASE;
	assign sub_rel = wb_adr - ADR_SUBKEY_BASE;
	assign key_sel = key_rel < adr_t'(KEY_WORDS_MAX);
	assign sub_sel = sub_rel < adr_t'(P_COUNT);
	assign key_off = key_idx_t'(key_rel);
	assign sub_off = p_idx_t'(sub_rel);

	assign len_ok = (key_len_q != '0) && (key_len_q <= key_len_t'(KEY_WORDS_MAX));

	always_ff @(posedge Clk or negedge RstN) begin
		if (!RstN) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= access;
		end
	end

	// ----------------------------------------
	// key store and control
	// ----------------------------------------
	always_ff @(posedge Clk) begin
		if (wr && key_sel && !key.busy) begin
			key_mem[key_off] <= wb_dat_w;
		end
	end

	always_ff @(posedge Clk or negedge RstN) begin
		if (!RstN) begin
			key_len_q <= '0;
			decrypt_q <= 1'b0;
			len_err_q <= 1'b0;
			start_q   <= 1'b0;
		end else begin
			start_q <= 1'b0;
			if (wr && wb_adr == ADR_KEYLEN && !key.busy) begin
				key_len_q <= key_len_t'(wb_dat_w);
			end
			if (wr && wb_adr == ADR_CTRL) begin
				decrypt_q <= wb_dat_w[CTRL_DECRYPT];
				// start lands in the ack cycle
				if (wb_dat_w[CTRL_START] && !key.busy) begin
					if (len_ok) begin
						start_q   <= 1'b1;
						len_err_q <= 1'b0;
					end else begin
						len_err_q <= 1'b1;
					end
				end
			end
		end
	end

	assign key.start    = start_q;
	assign key.key_len  = key_len_q;
	assign key.key_word = key_mem[key.key_idx];

	// decryption order reads the array back to front
	assign key.sub_idx = decrypt_q ? (p_idx_t'(P_COUNT - 1) - sub_off) : sub_off;

	// ----------------------------------------
	// read path
	// ----------------------------------------
	always_comb begin
		rd_data = '0;
		if (key_sel) begin
			rd_data = key_mem[key_off];
		end else if (sub_sel) begin
			rd_data = key.sub_word;
		end else begin
			case (wb_adr)
				ADR_CTRL: rd_data[CTRL_DECRYPT] = decrypt_q;
				ADR_KEYLEN: rd_data = word_t'(key_len_q);
				ADR_STATUS: begin
					rd_data[STAT_READY]   = key.ready;
					rd_data[STAT_BUSY]    = key.busy;
					rd_data[STAT_LEN_ERR] = len_err_q;
				end
				default: rd_data = '0;
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (access && !wb_we) begin
			wb_dat_r <= rd_data;
		end
	end

endmodule

`default_nettype wire

/* src/bf_parray_mixer.sv */
// Serial key mixing, one P-array entry per cycle
// every entry is rebuilt from P_INIT, so a restart gives the same result
// start to ready takes 21 clock edges
`timescale 1ns/1ps
`default_nettype none

module bf_parray_mixer (
	input logic     Clk,
	input logic     RstN,
	bf_key_if.mixer key
);
	import bf_cipher_pkg::*;
	import bf_regmap_pkg::*;

	mix_state_t state;
	word_t      p_array [P_COUNT];
	p_idx_t     p_idx;
	key_idx_t   k_idx;
	key_idx_t   k_next;
	key_len_t   len_q;
	logic       last_entry;

	assign last_entry = (p_idx == p_idx_t'(P_COUNT - 1));
	assign k_next     = k_idx + key_idx_t'(1);

	// ----------------------------------------
	// control FSM
	// ----------------------------------------
	always_ff @(posedge Clk or negedge RstN) begin
		if (!RstN) begin
			state <= ST_IDLE;
			p_idx <= '0;
			k_idx <= '0;
			len_q <= '0;
		end else begin
			case (state)
				ST_IDLE, ST_DONE: begin
					if (key.start) begin
						state <= ST_MIX;
						p_idx <= '0;
						k_idx <= '0;
						len_q <= key.key_len;
					end
				end
				ST_MIX: begin
					p_idx <= p_idx + p_idx_t'(1);
					// key index wraps at the captured length
					if (k_next == key_idx_t'(len_q)) begin
						k_idx <= '0;
					end else begin
						k_idx <= k_next;
					end
					if (last_entry) begin
						state <= ST_DONE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// P-array storage
	// ----------------------------------------
	always_ff @(posedge Clk or negedge RstN) begin
		if (!RstN) begin
			for (int i = 0; i < P_COUNT; i++) begin
				p_array[i] <= P_INIT[i];
			end
		end else if (state == ST_MIX) begin
			p_array[p_idx] <= P_INIT[p_idx] ^ key.key_word;
		end
	end

	assign key.key_idx = k_idx;
	assign key.busy    = (state == ST_MIX);
	assign key.ready   = (state == ST_DONE);

	// out of range indices read as zero
	assign key.sub_word = (key.sub_idx < p_idx_t'(P_COUNT)) ? p_array[key.sub_idx] : '0;

endmodule

`default_nettype wire

/* src/bf_skeygen_top.sv */
// Blowfish P-array key mixing with a Wishbone classic slave port
// full-word accesses only, ack latency is always one cycle
// poll the status register for ready after a start
`timescale 1ns/1ps
`default_nettype none

module bf_skeygen_top (
	input  logic                 Clk,
	input  logic                 RstN,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  bf_regmap_pkg::adr_t  wb_adr,
	input  bf_cipher_pkg::word_t wb_dat_w,
	output bf_cipher_pkg::word_t wb_dat_r,
	output logic                 wb_ack
);

	// register block to mixer
	bf_key_if key_bus ();

	bf_wb_regs u_regs (
		.Clk      (Clk),
		.RstN     (RstN),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.key      (key_bus.regs)
	);

	bf_parray_mixer u_mixer (
		.Clk  (Clk),
		.RstN (RstN),
		.key  (key_bus.mixer)
	);

endmodule

`default_nettype wire

/* test/bf_skeygen_assert.sv */
// Concurrent checks on the Wishbone handshake and the mixer status
// assumes the master holds cyc and stb through the edge that ends ack
`timescale 1ns/1ps
`default_nettype none

module bf_skeygen_assert (
	input logic Clk,
	input logic RstN,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic start,
	input logic busy,
	input logic ready
);

	int fail_count = 0;

	// ack only inside an active cycle
	ack_in_cycle: assert property (@(posedge Clk) disable iff (!RstN)
		wb_ack |-> (wb_cyc && wb_stb))
	else begin
		fail_count++;
		$error("ack raised without cyc and stb");
	end

	ack_single: assert property (@(posedge Clk) disable iff (!RstN)
		wb_ack |=> !wb_ack)
	else begin
		fail_count++;
		$error("ack high in two consecutive cycles");
	end

	busy_ready_excl: assert property (@(posedge Clk) disable iff (!RstN)
		!(busy && ready))
	else begin
		fail_count++;
		$error("busy and ready high together");
	end

	// a restart in the middle of a run would corrupt the array
	no_start_busy: assert property (@(posedge Clk) disable iff (!RstN)
		start |-> !busy)
	else begin
		fail_count++;
		$error("start pulse while the mixer is busy");
	end

endmodule

bind bf_skeygen_top bf_skeygen_assert u_assert (
	.Clk    (Clk),
	.RstN   (RstN),
	.wb_cyc (wb_cyc),
	.wb_stb (wb_stb),
	.wb_ack (wb_ack),
	.start  (key_bus.start),
	.busy   (key_bus.busy),
	.ready  (key_bus.ready)
);

`default_nettype wire

/* test/tb_bf_skeygen.sv */
// Directed tests for the P-array key mixing block over Wishbone
// expected subkeys come from P_INIT[i] XOR key[i mod len]
`timescale 1ns/1ps
`default_nettype none

module tb_bf_skeygen;
	import bf_cipher_pkg::*;
	import bf_regmap_pkg::*;

	localparam int ACK_TIMEOUT = 10;
	localparam int READY_POLLS = 40;

	logic  Clk;
	logic  RstN;
	logic  wb_cyc;
	logic  wb_stb;
	logic  wb_we;
	adr_t  wb_adr;
	word_t wb_dat_w;
	word_t wb_dat_r;
	logic  wb_ack;

	int    err_count;
	int    timeout_count;
	word_t key_words [KEY_WORDS_MAX];
	word_t expected [P_COUNT];

	bf_skeygen_top dut (
		.Clk      (Clk),
		.RstN     (RstN),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	// ----------------------------------------
	// bus master
	// ----------------------------------------
	task automatic wb_access(input logic we, input adr_t adr, input word_t wdata,
			output word_t rdata);
		int   waited;
		logic got_ack;
		waited  = 0;
		got_ack = 1'b0;
		rdata   = '0;
		@(negedge Clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		while (!got_ack && waited < ACK_TIMEOUT) begin
			@(negedge Clk);
			waited++;
			got_ack = wb_ack;
		end
		if (got_ack) begin
			rdata = wb_dat_r;
		end else begin
			$display("no ack for access to address 0x%02h", adr);
			timeout_count++;
		end
		// hold through the edge that ends ack
		@(negedge Clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input adr_t adr, input word_t data);
		word_t unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input adr_t adr, output word_t data);
		wb_access(1'b0, adr, '0, data);
	endtask

	task automatic compare_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic wait_ready();
		word_t status;
		int    polls;
		polls  = 0;
		status = '0;
		while (!status[STAT_READY] && polls < READY_POLLS) begin
			wb_read(ADR_STATUS, status);
			polls++;
		end
		if (!status[STAT_READY]) begin
			$display("mixer never reported ready");
			timeout_count++;
		end
	endtask

	// ----------------------------------------
	// reference model and helpers
	// ----------------------------------------
	task automatic load_key(input int len);
		for (int i = 0; i < len; i++) begin
			key_words[i] = $urandom;
			wb_write(ADR_KEY_BASE + adr_t'(i), key_words[i]);
		end
		wb_write(ADR_KEYLEN, word_t'(len));
	endtask

	task automatic fill_expected(input int len);
		for (int i = 0; i < P_COUNT; i++) begin
			expected[i] = P_INIT[i] ^ key_words[i % len];
		end
	endtask

	task automatic check_subkeys(input logic decrypt);
		word_t got;
		word_t exp;
		for (int j = 0; j < P_COUNT; j++) begin
			wb_read(ADR_SUBKEY_BASE + adr_t'(j), got);
			exp = decrypt ? expected[P_COUNT - 1 - j] : expected[j];
			compare_word($sformatf("subkey %0d", j), got, exp);
		end
	endtask

	task automatic mix_key(input int len);
		word_t status;
		load_key(len);
		wb_write(ADR_CTRL, 32'h1);
		wait_ready();
		fill_expected(len);
		wb_read(ADR_STATUS, status);
		compare_word("status after mix", status, 32'h1);
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic after_reset_values();
		word_t status;
		wb_read(ADR_STATUS, status);
		compare_word("status after reset", status, 32'h0);
		for (int i = 0; i < P_COUNT; i++) begin
			expected[i] = P_INIT[i];
		end
		check_subkeys(1'b0);
	endtask

	task automatic bad_key_length();
		word_t status;
		for (int k = 0; k < 2; k++) begin
			wb_write(ADR_KEYLEN, (k == 0) ? 32'd0 : 32'd15);
			wb_write(ADR_CTRL, 32'h1);
			wb_read(ADR_STATUS, status);
			compare_word("status after bad length", status, 32'h4);
			check_subkeys(1'b0);
		end
		// a good start clears the error
		mix_key(3);
		check_subkeys(1'b0);
	endtask

	task automatic all_key_lengths();
		for (int len = 1; len <= KEY_WORDS_MAX; len++) begin
			mix_key(len);
			check_subkeys(1'b0);
		end
	endtask

	task automatic decrypt_order();
		mix_key(5);
		wb_write(ADR_CTRL, 32'h2);
		check_subkeys(1'b1);
		wb_write(ADR_CTRL, 32'h0);
		check_subkeys(1'b0);
	endtask

	task automatic repeated_start();
		word_t status;
		mix_key(7);
		check_subkeys(1'b0);
		// same key again, the array restarts from P_INIT
		wb_write(ADR_CTRL, 32'h1);
		wb_read(ADR_STATUS, status);
		compare_word("status after restart", status, 32'h2);
		wait_ready();
		check_subkeys(1'b0);
	endtask

	task automatic write_while_busy();
		word_t status;
		word_t got;
		load_key(4);
		wb_write(ADR_CTRL, 32'h1);
		wb_write(ADR_KEY_BASE, ~key_words[0]);
		wb_write(ADR_KEYLEN, 32'd9);
		// a second start in the middle of the run must be dropped
		wb_write(ADR_CTRL, 32'h1);
		wb_read(ADR_STATUS, status);
		compare_word("status while mixing", status, 32'h2);
		wait_ready();
		fill_expected(4);
		check_subkeys(1'b0);
		wb_read(ADR_KEY_BASE, got);
		compare_word("key word 0", got, key_words[0]);
		wb_read(ADR_KEYLEN, got);
		compare_word("key length", got, 32'd4);
	endtask

	initial begin
		void'($urandom(32'ha090_f417));
		err_count     = 0;
		timeout_count = 0;
		RstN     = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		repeat (5) @(negedge Clk);
		RstN = 1'b1;

		after_reset_values();
		bad_key_length();
		all_key_lengths();
		decrypt_order();
		repeated_start();
		write_while_busy();

		$display("errors: %0d mismatch, %0d timeout, %0d assertion",
			err_count, timeout_count, dut.u_assert.fail_count);
		if (err_count == 0 && timeout_count == 0 && dut.u_assert.fail_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
src/bf_cipher_pkg.sv
src/bf_regmap_pkg.sv
src/bf_key_if.sv
src/bf_wb_regs.sv
src/bf_parray_mixer.sv
src/bf_skeygen_top.sv
test/bf_skeygen_assert.sv
test/tb_bf_skeygen.sv

/* Makefile */
# Verilator build and run for the Blowfish subkey generator

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_bf_skeygen
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
